// File: pe_cases.txt
// mode last top_valid left_valid top0 top1 top2 top3 left0 left1 left2 left3 gap, all hex
// Mode 0 is stream, 1 is bcast and 2 is the reserved trace code. Mode ff ends the list
0 0 1 1 00000001 00000002 00000003 00000004 00000005 0000aaaa 0000bbbb 0000cccc 0
0 0 1 1 00000010 00000020 00000030 00000040 00000003 11111111 22222222 33333333 0
0 1 1 1 ffffffff 80000000 00001000 00000007 00000009 deadbeef 01234567 89abcdef 3
1 0 1 1 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000009 0
1 0 1 1 10000000 00000100 ffff0000 00000011 00000010 00001000 00010000 00000022 0
1 1 1 1 00000001 00000001 00000001 00000001 fffffffe fffffffd 00000003 00000004 0
0 0 1 1 00000007 00000008 00000009 0000000a 00000002 00000000 00000000 00000000 0
0 1 1 1 00000100 00000200 00000300 00000400 0000ffff 12345678 9abcdef0 0fedcba9 2
0 1 1 0 00000005 00000005 00000005 00000005 00000005 00000005 00000005 00000005 1
1 1 0 1 00000006 00000006 00000006 00000006 00000006 00000006 00000006 00000006 1
2 1 1 1 00000007 00000007 00000007 00000007 00000007 00000007 00000007 00000007 1
0 1 1 1 0000000b 0000000c 0000000d 0000000e 00000003 00000000 00000000 00000000 0
1 1 1 1 00000002 00000002 00000002 00000002 00000004 00000005 00000006 00000007 0
0 0 1 1 12345678 87654321 0badf00d 00c0ffee 00000011 00000000 00000000 00000000 0
0 0 0 1 aaaaaaaa bbbbbbbb cccccccc dddddddd eeeeeeee 00000000 00000000 00000000 0
0 1 1 1 00000003 00000003 00000003 00000003 80000001 00000000 00000000 00000000 4
ff 0 0 0 0 0 0 0 0 0 0 0 0

// File: verilog.f
+incdir+.
pe_data_pkg.sv
pe_ctrl_pkg.sv
pe_delay_line.sv
pe_decode.sv
pe_mul_array.sv
pe_stream_acc.sv
pe_bcast_reduce.sv
pe_top.sv
pe_chk.sv
tb_pe.sv

// File: Bender.yml
package:
  name: pe

sources:
  - include_dirs:
      - .
    files:
      - pe_data_pkg.sv
      - pe_ctrl_pkg.sv
      - pe_delay_line.sv
      - pe_decode.sv
      - pe_mul_array.sv
      - pe_stream_acc.sv
      - pe_bcast_reduce.sv
      - pe_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - pe_chk.sv
      - tb_pe.sv

// File: tb_pe.sv
`timescale 1ns/10ps
`include "pe_config.svh"

// Reference model of the PE that compares every DUT result on its due cycle
module pe_monitor (
    input  logic               clk,
    input  logic               rst_n,
    input  pe_ctrl_pkg::mode_e mode,
    input  logic               last,
    input  pe_data_pkg::vec_t  top_data,
    input  logic               top_valid,
    input  pe_data_pkg::vec_t  left_data,
    input  logic               left_valid,
    input  pe_data_pkg::lane_t fwd_data,
    input  logic               fwd_valid,
    input  pe_data_pkg::vec_t  stream_result,
    input  logic               stream_valid,
    input  pe_data_pkg::lane_t bcast_result,
    input  logic               bcast_valid,
    output int                 errors,
    output int                 checks,
    output int                 pending
);

    // Expected value and the monitor cycle it is due on
    typedef struct packed {
        int unsigned       due;
        pe_data_pkg::vec_t value;
    } expect_t;

    expect_t            fwd_q[$];
    expect_t            stream_q[$];
    expect_t            bcast_q[$];
    pe_data_pkg::vec_t  stream_acc;
    pe_data_pkg::lane_t bcast_acc;
    int unsigned        cycle;

    // Queue head must show up on its due cycle, any other strobe is stray
    task automatic check_output(ref expect_t q[$], input logic valid,
                                input pe_data_pkg::vec_t act, input int lanes,
                                input string name);
        string label;
        if (q.size() != 0 && q[0].due == cycle) begin
            if (!valid) begin
                errors++;
                $display("Missing %s strobe at time %0t", name, $time);
            end
            for (int i = 0; i < lanes && valid; i++) begin
                checks++;
                label = (lanes == 1) ? name : $sformatf("%s[%0d]", name, i);
                if (act[i] !== q[0].value[i]) begin
                    errors++;
                    $display("Error at time %0t: %s expected %h, actual %h",
                             $time, label, q[0].value[i], act[i]);
                end
            end
            void'(q.pop_front());
        end else if (valid) begin
            errors++;
            $display("Unexpected %s strobe at time %0t", name, $time);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            stream_acc = '0;
            bcast_acc  = '0;
            if (fwd_valid || stream_valid || bcast_valid) begin
                errors++;
                $display("A valid output was high during reset at time %0t", $time);
            end
        end else begin
            cycle++;
            check_output(fwd_q, fwd_valid, pe_data_pkg::vec_t'(fwd_data), 1, "fwd_data");
            check_output(stream_q, stream_valid, stream_result, `PE_LANES, "stream_result");
            check_output(bcast_q, bcast_valid, pe_data_pkg::vec_t'(bcast_result), 1,
                         "bcast_result");
            // Streaming multiplies every top lane by left lane 0
            if (top_valid && left_valid && mode == pe_ctrl_pkg::stream) begin
                fwd_q.push_back(expect_t'{cycle + `PE_STREAM_LATENCY,
                                          pe_data_pkg::vec_t'(left_data[0])});
                for (int i = 0; i < `PE_LANES; i++) begin
                    stream_acc[i] += top_data[i] * left_data[0];
                end
                if (last) begin
                    stream_q.push_back(expect_t'{cycle + `PE_STREAM_LATENCY, stream_acc});
                    stream_acc = '0;
                end
            end
            // Broadcast sums the lane products into one word
            if (top_valid && left_valid && mode == pe_ctrl_pkg::bcast) begin
                for (int i = 0; i < `PE_LANES; i++) begin
                    bcast_acc += top_data[i] * left_data[i];
                end
                if (last) begin
                    bcast_q.push_back(expect_t'{cycle + `PE_BCAST_LATENCY,
                                                pe_data_pkg::vec_t'(bcast_acc)});
                    bcast_acc = '0;
                end
            end
            pending = fwd_q.size() + stream_q.size() + bcast_q.size();
        end
    end

endmodule

module tb_pe;

    // Words per case: mode, last, top_valid, left_valid, top lanes, left lanes, gap
    localparam int CASE_WORDS = 4 + 2 * `PE_LANES + 1;
    localparam int MAX_CASES  = 64;

    logic               clk;
    logic               rst_n;
    pe_ctrl_pkg::mode_e mode;
    logic               last;
    pe_data_pkg::vec_t  top_data;
    logic               top_valid;
    pe_data_pkg::vec_t  left_data;
    logic               left_valid;
    pe_data_pkg::lane_t fwd_data;
    logic               fwd_valid;
    pe_data_pkg::vec_t  stream_result;
    logic               stream_valid;
    pe_data_pkg::lane_t bcast_result;
    logic               bcast_valid;
    int                 errors;
    int                 checks;
    int                 pending;
    logic [31:0]        case_mem [CASE_WORDS*MAX_CASES];
    integer             seed;
    int                 num_cases;
    int                 cycle_limit;
    int                 run_cycles;
    int                 assert_fails;

    pe_top DUT (.*);

    pe_monitor u_mon (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic drive_idle();
        top_valid  = 1'b0;
        left_valid = 1'b0;
        last       = 1'b0;
        for (int i = 0; i < `PE_LANES; i++) begin
            top_data[i]  = $random(seed);
            left_data[i] = $random(seed);
        end
    endtask

    task automatic drive_case(input int k);
        int base;
        base       = k * CASE_WORDS;
        mode       = pe_ctrl_pkg::mode_e'(case_mem[base][1:0]);
        last       = case_mem[base+1][0];
        top_valid  = case_mem[base+2][0];
        left_valid = case_mem[base+3][0];
        for (int i = 0; i < `PE_LANES; i++) begin
            top_data[i]  = case_mem[base+4+i];
            left_data[i] = case_mem[base+4+`PE_LANES+i];
        end
    endtask

    initial begin
        int gap_total;
        seed       = 32'h60d1a3c3;
        rst_n      = 1'b0;
        mode       = pe_ctrl_pkg::stream;
        last       = 1'b0;
        top_valid  = 1'b0;
        left_valid = 1'b0;
        top_data   = '0;
        left_data  = '0;
        gap_total  = 0;
        num_cases  = 0;
        $readmemh("pe_cases.txt", case_mem);
        // A mode word of ff closes the list
        while (num_cases < MAX_CASES && case_mem[num_cases*CASE_WORDS] != 32'hff) begin
            gap_total += case_mem[num_cases*CASE_WORDS + CASE_WORDS - 1];
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("No stimulus cases could be read from pe_cases.txt");
        end
        cycle_limit = num_cases + gap_total + `PE_BCAST_LATENCY + 20;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < num_cases; k++) begin
            @(negedge clk);
            drive_case(k);
            repeat (case_mem[k*CASE_WORDS + CASE_WORDS - 1]) begin
                @(negedge clk);
                drive_idle();
            end
        end
        @(negedge clk);
        drive_idle();
        while (pending != 0) begin
            @(negedge clk);
        end
        // Quiet window long enough to see any stray late strobe
        repeat (`PE_BCAST_LATENCY) @(negedge clk);
        assert_fails = DUT.u_chk.fail_count;
        $display("Checks: %0d compared, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0 && num_cases != 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Cycle budget covers every case line, every gap and the deepest pipeline
    always @(posedge clk) begin
        if (rst_n) begin
            run_cycles++;
            if (run_cycles > cycle_limit) begin
                $display("Timeout after %0d cycles, the results never drained", cycle_limit);
                $display("Simulation failed");
                $finish;
            end
        end
    end

endmodule

// File: pe_chk.sv
`timescale 1ns/10ps
`include "pe_config.svh"

module pe_chk (
    input logic               clk,
    input logic               rst_n,
    input pe_ctrl_pkg::mode_e mode,
    input logic               last,
    input logic               top_valid,
    input logic               left_valid,
    input logic               fwd_valid,
    input logic               stream_valid,
    input logic               bcast_valid
);

    int   fail_count = 0;
    logic stream_item;
    logic bcast_item;

    assign stream_item = top_valid && left_valid && mode == pe_ctrl_pkg::stream;
    assign bcast_item  = top_valid && left_valid && mode == pe_ctrl_pkg::bcast;

    // --------------------
    // Every strobe traces back to its item

    assert property (@(posedge clk) disable iff (!rst_n)
        fwd_valid |-> $past(stream_item, `PE_STREAM_LATENCY))
    else begin
        fail_count++;
        $error("fwd_valid without an accepted stream item before it");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        stream_valid |-> $past(stream_item && last, `PE_STREAM_LATENCY))
    else begin
        fail_count++;
        $error("stream_valid without a last stream item before it");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        bcast_valid |-> $past(bcast_item && last, `PE_BCAST_LATENCY))
    else begin
        fail_count++;
        $error("bcast_valid without a last bcast item before it");
    end

    // Outputs stay quiet in reset
    assert property (@(posedge clk)
        !rst_n |-> !(fwd_valid || stream_valid || bcast_valid))
    else begin
        fail_count++;
        $error("A valid output is high while rst_n is low");
    end

endmodule

bind pe_top pe_chk u_chk (.*);

// File: pe_top.sv
`timescale 1ns/10ps
`include "pe_config.svh"

module pe_top (
    input  logic               clk,
    input  logic               rst_n,
    input  pe_ctrl_pkg::mode_e mode,
    input  logic               last,
    input  pe_data_pkg::vec_t  top_data,
    input  logic               top_valid,
    input  pe_data_pkg::vec_t  left_data,
    input  logic               left_valid,
    output pe_data_pkg::lane_t fwd_data,
    output logic               fwd_valid,
    output pe_data_pkg::vec_t  stream_result,
    output logic               stream_valid,
    output pe_data_pkg::lane_t bcast_result,
    output logic               bcast_valid
);

    // Forwarded word and its strobe move as one payload
    typedef struct packed {
        logic               valid;
        pe_data_pkg::lane_t word;
    } fwd_t;

    pe_ctrl_pkg::item_sb_t dec_sb;
    pe_ctrl_pkg::item_sb_t mul_sb;
    pe_data_pkg::vec_t     op_a;
    pe_data_pkg::vec_t     op_b;
    pe_data_pkg::prod_t    prod;
    pe_data_pkg::lane_t    dec_fwd_word;
    logic                  dec_fwd_valid;
    fwd_t                  fwd_in;
    fwd_t                  fwd_out;

    // --------------------
    // Decode

    pe_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode       (mode),
        .last       (last),
        .top_data   (top_data),
        .top_valid  (top_valid),
        .left_data  (left_data),
        .left_valid (left_valid),
        .sb         (dec_sb),
        .op_a       (op_a),
        .op_b       (op_b),
        .fwd_word   (dec_fwd_word),
        .fwd_valid  (dec_fwd_valid)
    );

    // --------------------
    // Execute

    pe_mul_array u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .sb_in  (dec_sb),
        .op_a   (op_a),
        .op_b   (op_b),
        .prod   (prod),
        .sb_out (mul_sb)
    );

    pe_stream_acc u_stream (
        .clk           (clk),
        .rst_n         (rst_n),
        .sb            (mul_sb),
        .prod          (prod),
        .stream_result (stream_result),
        .stream_valid  (stream_valid)
    );

    pe_bcast_reduce u_bcast (
        .clk          (clk),
        .rst_n        (rst_n),
        .sb           (mul_sb),
        .prod         (prod),
        .bcast_result (bcast_result),
        .bcast_valid  (bcast_valid)
    );

    // --------------------
    // Forward path, lined up with the streaming result

    assign fwd_in = '{valid: dec_fwd_valid, word: dec_fwd_word};

    pe_delay_line #(
        .payload_t (fwd_t),
        .DEPTH     (`PE_FWD_DEPTH)
    ) u_fwd_delay (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (fwd_in),
        .q     (fwd_out)
    );

    assign fwd_data  = fwd_out.word;
    assign fwd_valid = fwd_out.valid;

endmodule

// File: pe_bcast_reduce.sv
`timescale 1ns/10ps
`include "pe_config.svh"

module pe_bcast_reduce (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pe_ctrl_pkg::item_sb_t sb,
    input  pe_data_pkg::prod_t    prod,
    output pe_data_pkg::lane_t    bcast_result,
    output logic                  bcast_valid
);

    localparam int PAIRS = `PE_LANES / 2;

    pe_data_pkg::lane_t    pair_q [PAIRS];
    pe_data_pkg::lane_t    tree_q;
    pe_data_pkg::lane_t    tree_sum;
    pe_data_pkg::lane_t    acc_q;
    pe_data_pkg::lane_t    acc_sum;
    pe_ctrl_pkg::item_sb_t l1_sb;
    pe_ctrl_pkg::item_sb_t l2_sb;

    // --------------------
    // Tree level one adds neighbouring lanes

    always_ff @(posedge clk) begin
        for (int p = 0; p < PAIRS; p++) begin
            pair_q[p] <= prod[2*p] + prod[2*p+1];
        end
    end

    // --------------------
    // Tree level two folds the pair sums

    always_comb begin
        tree_sum = '0;
        for (int p = 0; p < PAIRS; p++) begin
            tree_sum = tree_sum + pair_q[p];
        end
    end

    always_ff @(posedge clk) begin
        tree_q <= tree_sum;
    end

    // Sideband staged with the tree, masked to broadcast items
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            l1_sb <= '0;
            l2_sb <= '0;
        end else begin
            l1_sb       <= sb;
            l1_sb.valid <= sb.valid && (sb.mode == pe_ctrl_pkg::bcast);
            l2_sb       <= l1_sb;
        end
    end

    // --------------------
    // Scalar accumulator

    assign acc_sum = acc_q + tree_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q       <= '0;
            bcast_valid <= 1'b0;
        end else begin
            bcast_valid <= l2_sb.valid && l2_sb.last;
            if (l2_sb.valid) begin
                acc_q <= l2_sb.last ? '0 : acc_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (l2_sb.valid && l2_sb.last) begin
            bcast_result <= acc_sum;
        end
    end

endmodule

// File: pe_stream_acc.sv
`timescale 1ns/10ps
`include "pe_config.svh"

module pe_stream_acc (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pe_ctrl_pkg::item_sb_t sb,
    input  pe_data_pkg::prod_t    prod,
    output pe_data_pkg::vec_t     stream_result,
    output logic                  stream_valid
);

    pe_data_pkg::vec_t acc_q;
    pe_data_pkg::vec_t acc_sum;
    logic              hit;

    // Only streaming items touch this accumulator
    assign hit = sb.valid && (sb.mode == pe_ctrl_pkg::stream);

    // --------------------
    // Lane adders

    always_comb begin
        for (int i = 0; i < `PE_LANES; i++) begin
            acc_sum[i] = acc_q[i] + prod[i];
        end
    end

    // --------------------
    // Accumulator and result strobe

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q        <= '0;
            stream_valid <= 1'b0;
        end else begin
            stream_valid <= 1'b0;
            if (hit) begin
                if (sb.last) begin
                    // Group closes, next item starts from zero
                    acc_q        <= '0;
                    stream_valid <= 1'b1;
                end else begin
                    acc_q <= acc_sum;
                end
            end
        end
    end

    // Result holds the sum including the last item
    always_ff @(posedge clk) begin
        if (hit && sb.last) begin
            stream_result <= acc_sum;
        end
    end

endmodule

// File: pe_mul_array.sv
`timescale 1ns/10ps
`include "pe_config.svh"

module pe_mul_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pe_ctrl_pkg::item_sb_t sb_in,
    input  pe_data_pkg::vec_t     op_a,
    input  pe_data_pkg::vec_t     op_b,
    output pe_data_pkg::prod_t    prod,
    output pe_ctrl_pkg::item_sb_t sb_out
);

    // Product pipeline, one entry per multiplier stage
    pe_data_pkg::prod_t mul_q [`PE_MUL_LATENCY];

    // --------------------
    // Lane multipliers

    // Product is kept modulo 2^32 per lane
    always_ff @(posedge clk) begin
        for (int l = 0; l < `PE_LANES; l++) begin
            mul_q[0][l] <= op_a[l] * op_b[l];
        end
        for (int s = 1; s < `PE_MUL_LATENCY; s++) begin
            mul_q[s] <= mul_q[s-1];
        end
    end

    assign prod = mul_q[`PE_MUL_LATENCY-1];

    // --------------------
    // Sideband follows the products stage for stage

    pe_delay_line #(
        .payload_t (pe_ctrl_pkg::item_sb_t),
        .DEPTH     (`PE_MUL_LATENCY)
    ) u_sb_delay (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (sb_in),
        .q     (sb_out)
    );

endmodule

// File: pe_decode.sv
`timescale 1ns/10ps
`include "pe_config.svh"

module pe_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pe_ctrl_pkg::mode_e    mode,
    input  logic                  last,
    input  pe_data_pkg::vec_t     top_data,
    input  logic                  top_valid,
    input  pe_data_pkg::vec_t     left_data,
    input  logic                  left_valid,
    output pe_ctrl_pkg::item_sb_t sb,
    output pe_data_pkg::vec_t     op_a,
    output pe_data_pkg::vec_t     op_b,
    output pe_data_pkg::lane_t    fwd_word,
    output logic                  fwd_valid
);

    logic              accept;
    pe_data_pkg::vec_t left_route;

    // Both operands present and a live mode
    assign accept = top_valid && left_valid &&
                    (mode == pe_ctrl_pkg::stream || mode == pe_ctrl_pkg::bcast);

    // --------------------
    // Left operand routing

    always_comb begin
        left_route = left_data;
        if (mode == pe_ctrl_pkg::stream) begin
            // Lane 0 is shared by every lane in streaming
            for (int i = 0; i < `PE_LANES; i++) begin
                left_route[i] = left_data[0];
            end
        end
    end

    // --------------------
    // Stage register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sb        <= '0;
            fwd_valid <= 1'b0;
        end else begin
            sb.valid  <= accept;
            sb.last   <= accept && last;
            sb.mode   <= mode;
            fwd_valid <= accept && (mode == pe_ctrl_pkg::stream);
        end
    end

    always_ff @(posedge clk) begin
        op_a     <= top_data;
        op_b     <= left_route;
        fwd_word <= left_data[0];
    end

endmodule

// File: pe_delay_line.sv
`timescale 1ns/10ps

module pe_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);

    // Register chain, stage 0 takes the input
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q = stage_q[DEPTH-1];

endmodule

// File: pe_ctrl_pkg.sv
package pe_ctrl_pkg;

    // --------------------
    // Operating mode

    // Trace encoding is kept reserved so old command streams decode the same
    typedef enum logic [1:0] {
        stream     = 2'b00,
        bcast      = 2'b01,
        trace_rsvd = 2'b10
    } mode_e;

    // --------------------
    // Sideband that rides beside an item through every stage

    typedef struct packed {
        logic  valid;
        logic  last;
        mode_e mode;
    } item_sb_t;

endpackage

// File: pe_data_pkg.sv
`include "pe_config.svh"

package pe_data_pkg;

    // --------------------
    // Datapath words

    // One SIMD lane
    typedef logic [`PE_DW-1:0] lane_t;

    // Operand vector, lane 0 in the low bits
    typedef lane_t [`PE_LANES-1:0] vec_t;

    // Multiplier output, low 32 bits of each lane product
    typedef lane_t [`PE_LANES-1:0] prod_t;

endpackage

// File: pe_config.svh
`ifndef PE_CONFIG_SVH
`define PE_CONFIG_SVH

// --------------------
// Datapath geometry
`define PE_LANES 4
`define PE_DW 32

// Pipeline depth of each lane multiplier
`define PE_MUL_LATENCY 3

// --------------------
// Latencies in cycles from the edge that samples an item
`define PE_STREAM_LATENCY (`PE_MUL_LATENCY + 2)
`define PE_BCAST_LATENCY (`PE_MUL_LATENCY + 4)

// Forward delay line depth behind the decode register
`define PE_FWD_DEPTH (`PE_STREAM_LATENCY - 1)

`endif
